// ==== hdl/bus_timers.sv ====
module bus_timers #(
  parameter int TURNAROUND_LIMIT = 101,
  parameter int RESPONSE_LIMIT   = 23,
  parameter int DATA_LIMIT       = 23
) (
  input  logic clock,
  input  logic reset,
  input  logic turnaround_start_i,
  input  logic response_start_i,
  input  logic data_start_i,
  input  logic hsk_recv_i,
  input  logic usb_busy_i,
  input  logic rx_start_i,
  output logic timeout_o
);

  logic ta_expired, ep_expired, td_expired;

  // Host handshake after IN data went out
  response_timer #(.LIMIT(TURNAROUND_LIMIT)) i_turnaround (
    .clock(clock), .reset(reset),
    .start_i(turnaround_start_i), .stop_i(hsk_recv_i), .expired_o(ta_expired)
  );

  // Endpoint has to start its packet after an IN
  response_timer #(.LIMIT(RESPONSE_LIMIT)) i_response (
    .clock(clock), .reset(reset),
    .start_i(response_start_i), .stop_i(usb_busy_i), .expired_o(ep_expired)
  );

  // DATAx from the host after OUT or SETUP
  response_timer #(.LIMIT(DATA_LIMIT)) i_token_data (
    .clock(clock), .reset(reset),
    .start_i(data_start_i), .stop_i(rx_start_i), .expired_o(td_expired)
  );

  always_ff @(posedge clock) begin
    if (reset) timeout_o <= 1'b0;
    else timeout_o <= ta_expired || ep_expired || td_expired;
  end

endmodule

// ==== hdl/endpoint_control.sv ====
module endpoint_control
  import usb_txn_pkg::*;
#(
  parameter usb_endp_t OUT_EP_NUM = 4'd1,
  parameter usb_endp_t IN_EP_NUM  = 4'd2
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       set_conf_i,
  input  logic       clr_conf_i,
  input  logic       crc_error_i,
  input  usb_addr_t  usb_addr_i,
  input  logic       tok_recv_i,
  input  usb_token_t token_i,
  input  usb_pid_t   data_pid_i,
  input  logic       hsk_recv_i,
  input  logic       hsk_sent_i,
  input  logic       timeout_i,
  input  logic       ep0_select_i,
  input  logic       ep0_parity_i,
  input  ep_status_t out_ep_i,
  input  ep_status_t in_ep_i,
  output ep_route_t  route_o,
  output ep_ctrl_t   out_ep_o,
  output ep_ctrl_t   in_ep_o
);

  logic out_en_q, in_en_q;
  logic crc_err_q, crc_ack_q;
  logic end_q;
  logic out_sel_q, in_sel_q;
  logic out_fin_q, in_fin_q;
  logic out_can_q, in_can_q;
  logic tok_hit;
  logic data_seq;

  // Bulk endpoints only run once the device is configured
  always_ff @(posedge clock) begin
    if (reset || clr_conf_i || out_ep_i.halted) begin
      out_en_q <= 1'b0;
    end else if (set_conf_i) begin
      out_en_q <= 1'b1;
    end
    if (reset || clr_conf_i || in_ep_i.halted) begin
      in_en_q <= 1'b0;
    end else if (set_conf_i) begin
      in_en_q <= 1'b1;
    end
  end

  // One pulse per CRC error, however long the decoder holds it
  always_ff @(posedge clock) begin
    if (reset || !crc_error_i) begin
      crc_err_q <= 1'b0;
      crc_ack_q <= 1'b0;
    end else begin
      crc_err_q <= !crc_ack_q;
      crc_ack_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    end_q <= reset || clr_conf_i || hsk_recv_i || hsk_sent_i || timeout_i || crc_err_q;
  end

  assign route_o.hit     = token_i.addr == usb_addr_i;
  assign route_o.ep0     = token_i.endp == 4'd0;
  assign route_o.out_sel = out_en_q && token_i.endp == OUT_EP_NUM;
  assign route_o.out_rdy = route_o.out_sel && !out_ep_i.halted && out_ep_i.rx_rdy;
  assign route_o.in_sel  = in_en_q && token_i.endp == IN_EP_NUM;
  assign route_o.in_rdy  = route_o.in_sel && !in_ep_i.halted && in_ep_i.tx_rdy;

  assign tok_hit  = tok_recv_i && route_o.hit;
  assign data_seq = data_pid_i == PID_DATA1;

  // DATAx sequence bit has to match the toggle of the endpoint being filled
  assign route_o.par_ok = (ep0_select_i && ep0_parity_i == data_seq) ||
                          (out_sel_q && out_ep_i.parity == data_seq);

  always_comb begin
    if (route_o.ep0) begin
      route_o.seq     = ep0_parity_i;
      route_o.mux_sel = 3'd0;
    end else if (token_i.endp == OUT_EP_NUM) begin
      route_o.seq     = out_ep_i.parity;
      route_o.mux_sel = 3'd1;
    end else if (token_i.endp == IN_EP_NUM) begin
      route_o.seq     = in_ep_i.parity;
      route_o.mux_sel = 3'd2;
    end else begin
      route_o.seq     = 1'b0;
      route_o.mux_sel = 3'd7;
    end
  end

  // Selects hold from the token until the transaction ends
  always_ff @(posedge clock) begin
    if (reset || end_q) begin
      out_sel_q <= 1'b0;
      in_sel_q  <= 1'b0;
    end else if (tok_hit) begin
      out_sel_q <= route_o.out_sel && !out_ep_i.halted;
      in_sel_q  <= route_o.in_sel && !in_ep_i.halted;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || end_q) begin
      out_fin_q <= 1'b0;
      in_fin_q  <= 1'b0;
      out_can_q <= 1'b0;
      in_can_q  <= 1'b0;
    end else begin
      out_fin_q <= out_sel_q && hsk_sent_i;
      in_fin_q  <= in_sel_q && hsk_recv_i;
      out_can_q <= out_sel_q && (crc_err_q || timeout_i);
      in_can_q  <= in_sel_q && (crc_err_q || timeout_i);
    end
  end

  assign out_ep_o = '{select: out_sel_q, finish: out_fin_q, cancel: out_can_q};
  assign in_ep_o  = '{select: in_sel_q, finish: in_fin_q, cancel: in_can_q};

endmodule

// ==== hdl/response_timer.sv ====
module response_timer #(
  parameter int LIMIT = 23
) (
  input  logic clock,
  input  logic reset,
  input  logic start_i,
  input  logic stop_i,
  output logic expired_o
);

  localparam int CW = $clog2(LIMIT + 1);

  logic [CW-1:0] count_q;
  logic          run_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      run_q     <= 1'b0;
      expired_o <= 1'b0;
    end else begin
      expired_o <= 1'b0;
      if (start_i) begin
        run_q <= 1'b1;
      end else if (run_q && (stop_i || count_q == '0)) begin
        run_q     <= 1'b0;
        expired_o <= !stop_i;  // underflow without the awaited event
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start_i) count_q <= CW'(LIMIT);
    else if (run_q) count_q <= count_q - 1'b1;
  end

endmodule

// ==== hdl/transaction_fsm.sv ====
module transaction_fsm
  import usb_txn_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      tok_recv_i,
  input  usb_pid_t  token_pid_i,
  input  ep_route_t route_i,
  input  logic      ep0_select_i,
  input  logic      usb_recv_i,
  input  logic      usb_sent_i,
  input  logic      hsk_sent_i,
  input  logic      hsk_recv_i,
  input  logic      eop_recv_i,
  input  logic      crc_error_i,
  input  logic      timeout_i,
  output logic      hsk_send_o,
  output usb_pid_t  ulpi_tuser_o,
  output logic      mux_enable_o,
  output logic [2:0] mux_select_o,
  output logic      turnaround_start_o,
  output logic      response_start_o,
  output logic      data_start_o
);

  txn_state_t state_q, state_d;
  usb_pid_t   pid_d;
  logic       tok_hit;

  assign tok_hit = tok_recv_i && route_i.hit;

  always_comb begin
    state_d = state_q;
    pid_d   = ulpi_tuser_o;
    case (state_q)
      ST_IDLE: begin
        if (tok_hit) begin
          case (token_pid_i)
            PID_SETUP: begin
              if (route_i.ep0) begin
                state_d = ST_RECV;
              end else begin
                state_d = ST_DROP;
                pid_d   = PID_STALL;
              end
            end
            PID_OUT: begin
              if (ep0_select_i || route_i.out_rdy) begin
                state_d = ST_RECV;
              end else begin
                // Enabled but full gets NAK, anything else is unsupported
                state_d = ST_DROP;
                if (route_i.out_sel) pid_d = PID_NAK;
                else pid_d = PID_STALL;
              end
            end
            PID_IN: begin
              if (route_i.seq) pid_d = PID_DATA1;
              else pid_d = PID_DATA0;
              if (ep0_select_i || route_i.in_rdy) begin
                state_d = ST_SEND;
              end else if (route_i.in_sel) begin
                state_d = ST_RESP;
                pid_d   = PID_NAK;
              end else begin
                // Nothing to send, wait for the bus to go quiet
                state_d = ST_WAIT;
              end
            end
            PID_PING: begin
              state_d = ST_RESP;
              if (ep0_select_i || route_i.out_rdy) pid_d = PID_ACK;
              else if (route_i.out_sel) pid_d = PID_NAK;
              else pid_d = PID_STALL;
            end
            default: state_d = ST_IDLE;
          endcase
        end
      end
      ST_RECV: begin
        if (usb_recv_i) begin
          // A repeated DATAx is dropped without a handshake
          if (route_i.par_ok) begin
            state_d = ST_RESP;
            pid_d   = PID_ACK;
          end else begin
            state_d = ST_IDLE;
          end
        end else if (timeout_i || crc_error_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_RESP: if (hsk_sent_i || timeout_i) state_d = ST_IDLE;
      ST_SEND: begin
        if (usb_sent_i) state_d = ST_WAIT;
        else if (timeout_i) state_d = ST_IDLE;
      end
      ST_WAIT: if (hsk_recv_i || timeout_i) state_d = ST_IDLE;
      ST_DROP: if (eop_recv_i || timeout_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  // Timer starts at the events each timer guards
  assign turnaround_start_o = state_q == ST_SEND && usb_sent_i;
  assign response_start_o   = state_q == ST_IDLE && tok_hit && token_pid_i == PID_IN;
  assign data_start_o       = state_q == ST_IDLE && tok_hit &&
                              (token_pid_i == PID_OUT || token_pid_i == PID_SETUP);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q      <= ST_IDLE;
      hsk_send_o   <= 1'b0;
      mux_enable_o <= 1'b0;
      mux_select_o <= 3'd0;
      ulpi_tuser_o <= PID_NAK;
    end else begin
      state_q      <= state_d;
      hsk_send_o   <= state_d == ST_RESP;
      mux_enable_o <= state_q == ST_SEND || state_q == ST_WAIT;
      ulpi_tuser_o <= pid_d;
      if (state_q == ST_IDLE && tok_hit) begin
        mux_select_o <= route_i.mux_sel;
      end
    end
  end

endmodule

// ==== hdl/usb_transaction.sv ====
module usb_transaction
  import usb_txn_pkg::*;
#(
  parameter usb_endp_t OUT_EP_NUM       = 4'd1,
  parameter usb_endp_t IN_EP_NUM        = 4'd2,
  parameter int        TURNAROUND_LIMIT = 101,
  parameter int        RESPONSE_LIMIT   = 23,
  parameter int        DATA_LIMIT       = 23
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       set_conf_i,
  input  logic       clr_conf_i,
  input  usb_addr_t  usb_addr_i,
  input  logic       crc_error_i,
  input  logic       tok_recv_i,
  input  usb_token_t token_i,
  input  usb_pid_t   data_pid_i,
  input  logic       usb_recv_i,
  input  logic       eop_recv_i,
  input  logic       hsk_recv_i,
  input  logic       rx_start_i,
  input  logic       hsk_sent_i,
  input  logic       usb_busy_i,
  input  logic       usb_sent_i,
  output logic       hsk_send_o,
  output usb_pid_t   ulpi_tuser_o,
  output logic       mux_enable_o,
  output logic [2:0] mux_select_o,
  input  logic       ep0_select_i,
  input  logic       ep0_parity_i,
  input  ep_status_t out_ep_i,
  input  ep_status_t in_ep_i,
  output ep_ctrl_t   out_ep_o,
  output ep_ctrl_t   in_ep_o,
  output logic       timedout_o
);

  ep_route_t route;
  logic      timeout;
  logic      turnaround_start, response_start, data_start;

  assign timedout_o = timeout;

  endpoint_control #(.OUT_EP_NUM(OUT_EP_NUM), .IN_EP_NUM(IN_EP_NUM)) i_endpoint_control (
    .clock(clock), .reset(reset),
    .set_conf_i(set_conf_i), .clr_conf_i(clr_conf_i), .crc_error_i(crc_error_i),
    .usb_addr_i(usb_addr_i), .tok_recv_i(tok_recv_i), .token_i(token_i),
    .data_pid_i(data_pid_i), .hsk_recv_i(hsk_recv_i), .hsk_sent_i(hsk_sent_i),
    .timeout_i(timeout), .ep0_select_i(ep0_select_i), .ep0_parity_i(ep0_parity_i),
    .out_ep_i(out_ep_i), .in_ep_i(in_ep_i),
    .route_o(route), .out_ep_o(out_ep_o), .in_ep_o(in_ep_o)
  );

  transaction_fsm i_transaction_fsm (
    .clock(clock), .reset(reset),
    .tok_recv_i(tok_recv_i), .token_pid_i(token_i.pid), .route_i(route),
    .ep0_select_i(ep0_select_i), .usb_recv_i(usb_recv_i), .usb_sent_i(usb_sent_i),
    .hsk_sent_i(hsk_sent_i), .hsk_recv_i(hsk_recv_i), .eop_recv_i(eop_recv_i),
    .crc_error_i(crc_error_i), .timeout_i(timeout),
    .hsk_send_o(hsk_send_o), .ulpi_tuser_o(ulpi_tuser_o),
    .mux_enable_o(mux_enable_o), .mux_select_o(mux_select_o),
    .turnaround_start_o(turnaround_start), .response_start_o(response_start),
    .data_start_o(data_start)
  );

  bus_timers #(
    .TURNAROUND_LIMIT(TURNAROUND_LIMIT),
    .RESPONSE_LIMIT(RESPONSE_LIMIT),
    .DATA_LIMIT(DATA_LIMIT)
  ) i_bus_timers (
    .clock(clock), .reset(reset),
    .turnaround_start_i(turnaround_start), .response_start_i(response_start),
    .data_start_i(data_start), .hsk_recv_i(hsk_recv_i), .usb_busy_i(usb_busy_i),
    .rx_start_i(rx_start_i), .timeout_o(timeout)
  );

endmodule

// ==== hdl/usb_txn_pkg.sv ====
package usb_txn_pkg;

  // PID nibble as it appears on the ULPI bus
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SETUP = 4'b1101,
    PID_PING  = 4'b0100,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } usb_pid_t;

  typedef logic [6:0] usb_addr_t;
  typedef logic [3:0] usb_endp_t;

  // Decoded token from the packet decoder
  typedef struct packed {
    usb_pid_t  pid;
    usb_addr_t addr;
    usb_endp_t endp;
  } usb_token_t;

  // Status reported by a bulk endpoint
  typedef struct packed {
    logic rx_rdy;
    logic tx_rdy;
    logic parity;
    logic halted;
  } ep_status_t;

  // Control strobes and select level for a bulk endpoint
  typedef struct packed {
    logic select;
    logic finish;
    logic cancel;
  } ep_ctrl_t;

  // Routing facts for the transaction FSM
  typedef struct packed {
    logic       hit;
    logic       ep0;
    logic       out_sel;
    logic       out_rdy;
    logic       in_sel;
    logic       in_rdy;
    logic       seq;
    logic       par_ok;
    logic [2:0] mux_sel;
  } ep_route_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RECV,
    ST_RESP,
    ST_DROP,
    ST_SEND,
    ST_WAIT
  } txn_state_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run the testbench
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing -f usb_transaction.f --top-module usb_transaction_tb -Mdir obj_dir
./obj_dir/Vusb_transaction_tb | tee sim.log
grep -qx "test passed" sim.log
echo "simulation passed"

// ==== usb_transaction.f ====
hdl/usb_txn_pkg.sv
hdl/response_timer.sv
hdl/bus_timers.sv
hdl/endpoint_control.sv
hdl/transaction_fsm.sv
hdl/usb_transaction.sv
verification/usb_transaction_check.sv
verification/usb_transaction_tb.sv

// ==== verification/usb_transaction_check.sv ====
module usb_transaction_check
  import usb_txn_pkg::*;
#(
  parameter usb_endp_t OUT_EP_NUM       = 4'd1,
  parameter usb_endp_t IN_EP_NUM        = 4'd2,
  parameter int        TURNAROUND_LIMIT = 101,
  parameter int        RESPONSE_LIMIT   = 23,
  parameter int        DATA_LIMIT       = 23
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       set_conf_i,
  input  logic       clr_conf_i,
  input  logic       crc_error_i,
  input  usb_addr_t  usb_addr_i,
  input  logic       tok_recv_i,
  input  usb_token_t token_i,
  input  usb_pid_t   data_pid_i,
  input  logic       usb_recv_i,
  input  logic       eop_recv_i,
  input  logic       hsk_recv_i,
  input  logic       rx_start_i,
  input  logic       hsk_sent_i,
  input  logic       usb_busy_i,
  input  logic       usb_sent_i,
  input  logic       ep0_select_i,
  input  logic       ep0_parity_i,
  input  ep_status_t out_ep_i,
  input  ep_status_t in_ep_i,
  input  logic       hsk_send_o,
  input  usb_pid_t   ulpi_tuser_o,
  input  logic       mux_enable_o,
  input  logic [2:0] mux_select_o,
  input  ep_ctrl_t   out_ep_o,
  input  ep_ctrl_t   in_ep_o,
  input  logic       timedout_o,
  output int         error_count,
  output int         check_count,
  output logic       model_busy
);

  txn_state_t st_q;
  usb_pid_t   pid_q;
  logic       pid_valid, hsk_q, mux_en_q;
  logic [2:0] mux_sel_q;
  logic       out_en, in_en, out_sel, in_sel, end_q;
  logic       out_fin, in_fin, out_can, in_can;
  logic       crc_prev, crc_pulse;
  // Timer index 2 turnaround, 1 endpoint response, 0 token to data
  logic [2:0] run, expd;
  int         cnt [3];
  logic       tmo;

  function automatic int timer_limit(input int k);
    if (k == 2) return TURNAROUND_LIMIT;
    if (k == 1) return RESPONSE_LIMIT;
    return DATA_LIMIT;
  endfunction

  assign model_busy = st_q != ST_IDLE || |run || |expd || tmo;

  initial begin
    error_count = 0;
    check_count = 0;
  end

  always @(posedge clock) begin
    txn_state_t st_d;
    usb_pid_t   pid_d;
    logic       tok_hit, is_ep0, o_sel, o_rdy, i_sel, i_rdy, seq, par_ok, data1;
    logic [2:0] msel, t_start, t_stop;
    tok_hit = tok_recv_i && token_i.addr == usb_addr_i;
    is_ep0  = token_i.endp == 4'd0;
    o_sel   = out_en && token_i.endp == OUT_EP_NUM;
    o_rdy   = o_sel && !out_ep_i.halted && out_ep_i.rx_rdy;
    i_sel   = in_en && token_i.endp == IN_EP_NUM;
    i_rdy   = i_sel && !in_ep_i.halted && in_ep_i.tx_rdy;
    data1   = data_pid_i == PID_DATA1;
    par_ok  = (ep0_select_i && ep0_parity_i == data1) ||
              (out_sel && out_ep_i.parity == data1);
    if (is_ep0) begin
      seq  = ep0_parity_i;
      msel = 3'd0;
    end else if (token_i.endp == OUT_EP_NUM) begin
      seq  = out_ep_i.parity;
      msel = 3'd1;
    end else if (token_i.endp == IN_EP_NUM) begin
      seq  = in_ep_i.parity;
      msel = 3'd2;
    end else begin
      seq  = 1'b0;
      msel = 3'd7;
    end
    st_d  = st_q;
    pid_d = pid_q;
    case (st_q)
      ST_IDLE: begin
        if (tok_hit) begin
          case (token_i.pid)
            PID_SETUP: begin
              st_d = is_ep0 ? ST_RECV : ST_DROP;
              if (!is_ep0) pid_d = PID_STALL;
            end
            PID_OUT: begin
              st_d = (ep0_select_i || o_rdy) ? ST_RECV : ST_DROP;
              if (!(ep0_select_i || o_rdy)) pid_d = o_sel ? PID_NAK : PID_STALL;
            end
            PID_IN: begin
              pid_d = seq ? PID_DATA1 : PID_DATA0;
              if (ep0_select_i || i_rdy) begin
                st_d = ST_SEND;
              end else if (i_sel) begin
                st_d  = ST_RESP;
                pid_d = PID_NAK;
              end else begin
                st_d = ST_WAIT;
              end
            end
            PID_PING: begin
              st_d = ST_RESP;
              if (ep0_select_i || o_rdy) pid_d = PID_ACK;
              else pid_d = o_sel ? PID_NAK : PID_STALL;
            end
            default: st_d = ST_IDLE;
          endcase
        end
      end
      ST_RECV: begin
        if (usb_recv_i) begin
          st_d = par_ok ? ST_RESP : ST_IDLE;
          if (par_ok) pid_d = PID_ACK;
        end else if (tmo || crc_error_i) begin
          st_d = ST_IDLE;
        end
      end
      ST_RESP: if (hsk_sent_i || tmo) st_d = ST_IDLE;
      ST_SEND: begin
        if (usb_sent_i) st_d = ST_WAIT;
        else if (tmo) st_d = ST_IDLE;
      end
      ST_WAIT: if (hsk_recv_i || tmo) st_d = ST_IDLE;
      ST_DROP: if (eop_recv_i || tmo) st_d = ST_IDLE;
      default: st_d = ST_IDLE;
    endcase
    t_start = {st_q == ST_SEND && usb_sent_i,
               st_q == ST_IDLE && tok_hit && token_i.pid == PID_IN,
               st_q == ST_IDLE && tok_hit &&
               (token_i.pid == PID_OUT || token_i.pid == PID_SETUP)};
    t_stop  = {hsk_recv_i, usb_busy_i, rx_start_i};

    // CRC error counts once per burst
    crc_pulse <= !reset && crc_error_i && !crc_prev;
    crc_prev  <= !reset && crc_error_i;

    end_q <= reset || clr_conf_i || hsk_recv_i || hsk_sent_i || tmo || crc_pulse;
    if (reset || clr_conf_i || out_ep_i.halted) out_en <= 1'b0;
    else if (set_conf_i) out_en <= 1'b1;
    if (reset || clr_conf_i || in_ep_i.halted) in_en <= 1'b0;
    else if (set_conf_i) in_en <= 1'b1;

    if (reset || end_q) begin
      out_sel <= 1'b0;
      in_sel  <= 1'b0;
      out_fin <= 1'b0;
      in_fin  <= 1'b0;
      out_can <= 1'b0;
      in_can  <= 1'b0;
    end else begin
      if (tok_hit) begin
        out_sel <= o_sel && !out_ep_i.halted;
        in_sel  <= i_sel && !in_ep_i.halted;
      end
      out_fin <= out_sel && hsk_sent_i;
      in_fin  <= in_sel && hsk_recv_i;
      out_can <= out_sel && (tmo || crc_pulse);
      in_can  <= in_sel && (tmo || crc_pulse);
    end

    if (reset) begin
      st_q      <= ST_IDLE;
      hsk_q     <= 1'b0;
      mux_en_q  <= 1'b0;
      pid_valid <= 1'b0;
      run       <= '0;
      expd      <= '0;
      tmo       <= 1'b0;
    end else begin
      st_q     <= st_d;
      pid_q    <= pid_d;
      hsk_q    <= st_d == ST_RESP;
      mux_en_q <= st_q == ST_SEND || st_q == ST_WAIT;
      if (st_q == ST_IDLE && tok_hit) begin
        mux_sel_q <= msel;
      end
      // PID is only defined once a transaction has chosen one
      if (st_d != ST_IDLE && st_d != ST_RECV) pid_valid <= 1'b1;
      tmo <= |expd;
      for (int k = 0; k < 3; k++) begin
        if (t_start[k]) begin
          run[k]  <= 1'b1;
          expd[k] <= 1'b0;
          cnt[k]  <= timer_limit(k);
        end else begin
          expd[k] <= run[k] && !t_stop[k] && cnt[k] == 0;
          if (run[k] && (t_stop[k] || cnt[k] == 0)) run[k] <= 1'b0;
          cnt[k] <= cnt[k] - 1;
        end
      end
    end
  end

  task automatic compare(input string name, input logic [7:0] expv, input logic [7:0] gotv);
    check_count++;
    if (gotv !== expv) begin
      error_count++;
      $display("error %s expected %h got %h", name, expv, gotv);
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clock) begin
    if (!reset) begin
      compare("hsk_send_o", 8'(hsk_q), 8'(hsk_send_o));
      compare("mux_enable_o", 8'(mux_en_q), 8'(mux_enable_o));
      if (mux_en_q) compare("mux_select_o", 8'(mux_sel_q), 8'(mux_select_o));
      if (pid_valid) compare("ulpi_tuser_o", 8'(pid_q), 8'(ulpi_tuser_o));
      compare("out_ep_o.select", 8'(out_sel), 8'(out_ep_o.select));
      compare("out_ep_o.finish", 8'(out_fin), 8'(out_ep_o.finish));
      compare("out_ep_o.cancel", 8'(out_can), 8'(out_ep_o.cancel));
      compare("in_ep_o.select", 8'(in_sel), 8'(in_ep_o.select));
      compare("in_ep_o.finish", 8'(in_fin), 8'(in_ep_o.finish));
      compare("in_ep_o.cancel", 8'(in_can), 8'(in_ep_o.cancel));
      compare("timedout_o", 8'(tmo), 8'(timedout_o));
    end
  end

endmodule

// ==== verification/usb_transaction_tb.sv ====
module usb_transaction_tb;
  import usb_txn_pkg::*;

  localparam usb_endp_t OUT_EP_NUM       = 4'd1;
  localparam usb_endp_t IN_EP_NUM        = 4'd2;
  localparam int        TURNAROUND_LIMIT = 101;
  localparam int        RESPONSE_LIMIT   = 23;
  localparam int        DATA_LIMIT       = 23;
  localparam int        NUM_TXN          = 300;
  localparam int        TIMEOUT_CYCLES   = NUM_TXN * (TURNAROUND_LIMIT + 40);
  localparam usb_addr_t DEV_ADDR         = 7'h2a;

  logic       clock, reset;
  logic       set_conf_i, clr_conf_i, crc_error_i;
  usb_addr_t  usb_addr_i;
  logic       tok_recv_i;
  usb_token_t token_i;
  usb_pid_t   data_pid_i;
  logic       usb_recv_i, eop_recv_i, hsk_recv_i, rx_start_i;
  logic       hsk_sent_i, usb_busy_i, usb_sent_i;
  logic       ep0_select_i, ep0_parity_i;
  ep_status_t out_ep_i, in_ep_i;
  logic       hsk_send_o, mux_enable_o, timedout_o;
  usb_pid_t   ulpi_tuser_o;
  logic [2:0] mux_select_o;
  ep_ctrl_t   out_ep_o, in_ep_o;
  int         error_count, check_count, cycle_count;
  logic       model_busy;
  logic [15:0] lfsr;

  usb_transaction #(
    .OUT_EP_NUM(OUT_EP_NUM), .IN_EP_NUM(IN_EP_NUM), .TURNAROUND_LIMIT(TURNAROUND_LIMIT),
    .RESPONSE_LIMIT(RESPONSE_LIMIT), .DATA_LIMIT(DATA_LIMIT)
  ) i_usb_transaction (.*);

  usb_transaction_check #(
    .OUT_EP_NUM(OUT_EP_NUM), .IN_EP_NUM(IN_EP_NUM), .TURNAROUND_LIMIT(TURNAROUND_LIMIT),
    .RESPONSE_LIMIT(RESPONSE_LIMIT), .DATA_LIMIT(DATA_LIMIT)
  ) i_check (.*);

  always #2 clock = ~clock;

  // Galois LFSR, one step per bit taken
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr[0]);
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic clear_strobes();
    tok_recv_i  <= 1'b0;
    rx_start_i  <= 1'b0;
    usb_recv_i  <= 1'b0;
    eop_recv_i  <= 1'b0;
    usb_busy_i  <= 1'b0;
    usb_sent_i  <= 1'b0;
    hsk_sent_i  <= 1'b0;
    hsk_recv_i  <= 1'b0;
    crc_error_i <= 1'b0;
  endtask

  task automatic run_transaction();
    logic [1:0] kind, ep_sel;
    logic       hit_addr, withhold, busy_now, bad_crc;
    usb_endp_t  endp;
    usb_pid_t   pid;
    int         d1, d2, d3, hs_at, sent_at;
    // Configuration and endpoint status change only between transactions
    @(posedge clock);
    set_conf_i   <= rand_bits(2) == 0;
    clr_conf_i   <= rand_bits(4) == 0;
    out_ep_i     <= '{rx_rdy: rand_bits(2) != 0, tx_rdy: 1'b0,
                      parity: rand_bits(1) != 0, halted: rand_bits(4) == 0};
    in_ep_i      <= '{rx_rdy: 1'b0, tx_rdy: rand_bits(2) != 0,
                      parity: rand_bits(1) != 0, halted: rand_bits(4) == 0};
    ep0_parity_i <= rand_bits(1) != 0;
    @(posedge clock);
    set_conf_i <= 1'b0;
    clr_conf_i <= 1'b0;
    kind     = 2'(rand_bits(2));
    ep_sel   = 2'(rand_bits(2));
    hit_addr = rand_bits(2) != 0;
    withhold = rand_bits(3) == 0;
    bad_crc  = rand_bits(3) == 0;
    d1 = 1 + rand_bits(3);
    d2 = 1 + rand_bits(3);
    d3 = 1 + rand_bits(3);
    case (kind)
      2'd0: pid = PID_OUT;
      2'd1: pid = PID_IN;
      2'd2: pid = PID_SETUP;
      default: pid = PID_PING;
    endcase
    case (ep_sel)
      2'd0: endp = 4'd0;
      2'd1: endp = OUT_EP_NUM;
      2'd2: endp = IN_EP_NUM;
      default: endp = 4'd5;
    endcase
    @(posedge clock);
    tok_recv_i   <= 1'b1;
    token_i      <= '{pid: pid, endp: endp,
                      addr: hit_addr ? DEV_ADDR : DEV_ADDR ^ 7'(1 + rand_bits(6))};
    ep0_select_i <= hit_addr && endp == 4'd0;
    hs_at   = -1;
    sent_at = -1;
    // Host and encoder answer the DUT after random delays
    for (int step = 0; step < 60; step++) begin
      @(negedge clock);
      busy_now = 1'b0;
      if (hsk_send_o && hs_at < 0) hs_at = step + d3;
      if (mux_enable_o && sent_at < 0) begin
        sent_at  = step + d2;
        busy_now = !withhold;
      end
      @(posedge clock);
      clear_strobes();
      if ((pid == PID_OUT || pid == PID_SETUP) && !withhold) begin
        if (step == d1) rx_start_i <= 1'b1;
        if (step == d1 + 2 && bad_crc) begin
          // Corrupted DATAx holds the CRC error for two cycles
          crc_error_i <= 1'b1;
          eop_recv_i  <= 1'b1;
        end else if (step == d1 + 2) begin
          usb_recv_i <= 1'b1;
          eop_recv_i <= 1'b1;
          data_pid_i <= (rand_bits(1) != 0) ? PID_DATA1 : PID_DATA0;
        end
        if (step == d1 + 3 && bad_crc) crc_error_i <= 1'b1;
      end
      if (busy_now) usb_busy_i <= 1'b1;
      if (step == sent_at) usb_sent_i <= 1'b1;
      if (sent_at >= 0 && step == sent_at + d3 && !withhold) hsk_recv_i <= 1'b1;
      if (step == hs_at) hsk_sent_i <= 1'b1;
    end
    @(posedge clock);
    clear_strobes();
    ep0_select_i <= 1'b0;
    // Let the timers run out before the next token
    @(negedge clock);
    while (model_busy) @(negedge clock);
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    lfsr         = 16'd19;
    set_conf_i   = 1'b0;
    clr_conf_i   = 1'b0;
    crc_error_i  = 1'b0;
    usb_addr_i   = DEV_ADDR;
    token_i      = '{pid: PID_OUT, addr: 7'd0, endp: 4'd0};
    data_pid_i   = PID_DATA0;
    ep0_select_i = 1'b0;
    ep0_parity_i = 1'b0;
    out_ep_i     = '0;
    in_ep_i      = '0;
    clear_strobes();
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    for (int n = 0; n < NUM_TXN; n++) run_transaction();
    repeat (4) @(posedge clock);
    $display("%0d errors in %0d checks", error_count, check_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("%0d errors in %0d checks", error_count, check_count);
    $display("test failed");
    $finish;
  end

endmodule
